//--- ref_mem_defines.svh
`ifndef REF_MEM_DEFINES_SVH
`define REF_MEM_DEFINES_SVH

// reference bank geometry
`define NUM_BANKS 32
`define ADDR_W 7

// preload fills 4 banks at a time
`define GROUP_BANKS 4
`define PRE_GROUPS 8
`define PRE_LINES 96

// search scan geometry
`define ROWS_PER_HALF 24
`define STALL_FIRST 7
`define STALL_LAST 19
`define NUM_COLUMNS 7
`define SPLIT_STEP 8

`endif

//--- ref_mem_pkg.sv
`default_nettype none

`include "ref_mem_defines.svh"

package ref_mem_pkg;

	typedef enum logic [1:0] {
		ph_idle    = 2'd0,
		ph_preload = 2'd1,
		ph_search  = 2'd2,
		ph_done    = 2'd3
	} phase_t;

	// one enable bit per bank
	typedef logic [`NUM_BANKS-1:0] bank_mask_t;

	typedef logic [`ADDR_W-1:0] bank_addr_t;

	// bank 0 sits in the lowest slice
	typedef bank_addr_t [`NUM_BANKS-1:0] bank_addr_vec_t;

	// number of banks in the low group
	typedef logic [$clog2(`NUM_BANKS)-1:0] shift_t;

endpackage

`default_nettype wire

//--- ref_phase_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "ref_mem_defines.svh"

module ref_phase_decode import ref_mem_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   start,
	input  logic   pre_last,
	input  logic   scan_last,
	output phase_t phase,
	output logic   done
);

	logic start_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			start_q <= 1'b0;
			done <= 1'b0;
			phase <= ph_idle;
		end else begin
			// a start outside idle is dropped here
			start_q <= start && (phase == ph_idle);
			// lines up with the result stage register
			done <= (phase == ph_done);
			case (phase)
				ph_idle: begin
					if (start_q)
						phase <= ph_preload;
				end
				ph_preload: begin
					if (pre_last)
						phase <= ph_search;
				end
				ph_search: begin
					if (scan_last)
						phase <= ph_done;
				end
				default: begin
					phase <= ph_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- preload_counter.sv
`timescale 1ns/10ps
`default_nettype none

`include "ref_mem_defines.svh"

module preload_counter import ref_mem_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  phase_t     phase,
	output logic       pre_valid,
	output logic [2:0] pre_group,
	output bank_addr_t pre_line,
	output logic       pre_last
);

	logic [2:0] group_q;
	bank_addr_t line_q;
	logic       active;
	logic       line_end;

	assign active = (phase == ph_preload);
	assign line_end = (line_q == bank_addr_t'(`PRE_LINES - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			group_q <= 3'd0;
			line_q <= '0;
		end else if (!active) begin
			group_q <= 3'd0;
			line_q <= '0;
		end else if (line_end) begin
			// next group of four banks
			line_q <= '0;
			group_q <= group_q + 3'd1;
		end else begin
			line_q <= line_q + 1'b1;
		end
	end

	assign pre_valid = active;
	assign pre_group = group_q;
	assign pre_line = line_q;

	// last line of the last group
	assign pre_last = active && line_end && (group_q == 3'(`PRE_GROUPS - 1));

endmodule

`default_nettype wire

//--- search_scan.sv
`timescale 1ns/10ps
`default_nettype none

`include "ref_mem_defines.svh"

module search_scan import ref_mem_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  phase_t     phase,
	output logic       scan_valid,
	output bank_addr_t scan_row,
	output bank_addr_t scan_base,
	output shift_t     scan_split,
	output logic       scan_last
);

	logic [2:0] col_q;
	logic       half_q;
	bank_addr_t row_q;
	logic       stall_q;
	logic       active;
	logic [2:0] col_off;
	logic [1:0] blk_step;
	logic       in_window;
	logic       row_end;

	assign active = (phase == ph_search);
	assign col_off = col_q - 3'd1;
	assign in_window = (row_q >= bank_addr_t'(`STALL_FIRST)) &&
		(row_q <= bank_addr_t'(`STALL_LAST));
	assign row_end = (row_q == bank_addr_t'(`ROWS_PER_HALF - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			col_q <= 3'd1;
			half_q <= 1'b0;
			row_q <= '0;
			stall_q <= 1'b0;
		end else if (!active) begin
			col_q <= 3'd1;
			half_q <= 1'b0;
			row_q <= '0;
			stall_q <= 1'b0;
		end else if (in_window && !stall_q) begin
			// hold the row once for frame reuse
			stall_q <= 1'b1;
		end else begin
			stall_q <= 1'b0;
			if (row_end) begin
				row_q <= '0;
				half_q <= ~half_q;
				if (half_q)
					col_q <= col_q + 3'd1;
			end else begin
				row_q <= row_q + 1'b1;
			end
		end
	end

	// columns 5 to 7 start one block half further down
	assign blk_step = {1'b0, half_q} + {1'b0, col_off[2]};

	assign scan_valid = active;
	assign scan_row = row_q;
	assign scan_base = bank_addr_t'(blk_step * `ROWS_PER_HALF);
	assign scan_split = shift_t'(col_off[1:0] * `SPLIT_STEP);

	assign scan_last = active && (col_q == 3'(`NUM_COLUMNS)) && half_q && row_end;

endmodule

`default_nettype wire

//--- bank_addr_result.sv
`timescale 1ns/10ps
`default_nettype none

`include "ref_mem_defines.svh"

module bank_addr_result import ref_mem_pkg::*; (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           pre_valid,
	input  logic [2:0]     pre_group,
	input  bank_addr_t     pre_line,
	input  logic           scan_valid,
	input  bank_addr_t     scan_row,
	input  bank_addr_t     scan_base,
	input  shift_t         scan_split,
	output bank_mask_t     bank_sel,
	output bank_addr_vec_t wr_addr,
	output bank_addr_vec_t rd_addr,
	output logic           rd_en,
	output shift_t         shift_value
);

	bank_mask_t     group_mask;
	bank_addr_t     high_grp_addr;
	bank_addr_t     low_grp_addr;
	bank_addr_vec_t rd_addr_d;

	assign group_mask = bank_mask_t'({`GROUP_BANKS{1'b1}}) << (pre_group * `GROUP_BANKS);

	// low banks look one block half further down
	assign high_grp_addr = scan_base + scan_row;
	assign low_grp_addr = high_grp_addr + bank_addr_t'(`ROWS_PER_HALF);

	always_comb begin
		for (int i = 0; i < `NUM_BANKS; i++) begin
			if (i < scan_split)
				rd_addr_d[i] = low_grp_addr;
			else
				rd_addr_d[i] = high_grp_addr;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bank_sel <= '0;
			wr_addr <= '0;
			rd_addr <= '0;
			rd_en <= 1'b0;
			shift_value <= '0;
		end else begin
			if (pre_valid) begin
				bank_sel <= group_mask;
				wr_addr <= {`NUM_BANKS{pre_line}};
			end else begin
				bank_sel <= '0;
				wr_addr <= '0;
			end
			rd_en <= scan_valid;
			if (scan_valid) begin
				rd_addr <= rd_addr_d;
				shift_value <= scan_split;
			end else begin
				rd_addr <= '0;
				shift_value <= '0;
			end
		end
	end

endmodule

`default_nettype wire

//--- ref_mem_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "ref_mem_defines.svh"

module ref_mem_ctrl import ref_mem_pkg::*; (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           start,
	output bank_mask_t     bank_sel,
	output bank_addr_vec_t wr_addr,
	output bank_addr_vec_t rd_addr,
	output logic           rd_en,
	output shift_t         shift_value,
	output logic           done
);

	phase_t     phase;
	logic       pre_valid;
	logic [2:0] pre_group;
	bank_addr_t pre_line;
	logic       pre_last;
	logic       scan_valid;
	bank_addr_t scan_row;
	bank_addr_t scan_base;
	shift_t     scan_split;
	logic       scan_last;

	ref_phase_decode u_decode (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.pre_last  (pre_last),
		.scan_last (scan_last),
		.phase     (phase),
		.done      (done)
	);

	preload_counter u_preload (
		.clk       (clk),
		.rst_n     (rst_n),
		.phase     (phase),
		.pre_valid (pre_valid),
		.pre_group (pre_group),
		.pre_line  (pre_line),
		.pre_last  (pre_last)
	);

	search_scan u_scan (
		.clk        (clk),
		.rst_n      (rst_n),
		.phase      (phase),
		.scan_valid (scan_valid),
		.scan_row   (scan_row),
		.scan_base  (scan_base),
		.scan_split (scan_split),
		.scan_last  (scan_last)
	);

	bank_addr_result u_result (
		.clk         (clk),
		.rst_n       (rst_n),
		.pre_valid   (pre_valid),
		.pre_group   (pre_group),
		.pre_line    (pre_line),
		.scan_valid  (scan_valid),
		.scan_row    (scan_row),
		.scan_base   (scan_base),
		.scan_split  (scan_split),
		.bank_sel    (bank_sel),
		.wr_addr     (wr_addr),
		.rd_addr     (rd_addr),
		.rd_en       (rd_en),
		.shift_value (shift_value)
	);

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// reset held for four clock cycles
	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		#10 rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- ref_mem_ctrl_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "ref_mem_defines.svh"

module ref_mem_ctrl_tb import ref_mem_pkg::*; ();

	localparam int win_rows = `STALL_LAST - `STALL_FIRST + 1;
	localparam int half_reads = `ROWS_PER_HALF + win_rows;
	localparam int total_pre = `PRE_GROUPS * `PRE_LINES;
	localparam int total_reads = `NUM_COLUMNS * 2 * half_reads;
	// about three full runs
	localparam int cycle_limit = 4000;

	logic clk, rst_n, start, rd_en, done, in_pre;
	bank_mask_t bank_sel, exp_sel;
	bank_addr_vec_t wr_addr, rd_addr, exp_wr, exp_rd, prev_rd_addr;
	shift_t shift_value, exp_split;
	logic prev_in_pre, prev_rd_en, prev_done;
	int pre_cnt, rd_cnt, runs_done, seed;
	int error_cnt = 0;
	int cycle_cnt = 0;

	tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

	ref_mem_ctrl uut (
		.clk(clk), .rst_n(rst_n), .start(start), .bank_sel(bank_sel), .wr_addr(wr_addr),
		.rd_addr(rd_addr), .rd_en(rd_en), .shift_value(shift_value), .done(done)
	);

	function automatic bank_mask_t write_sel(input int k);
		bank_mask_t s;
		for (int b = 0; b < `NUM_BANKS; b++)
			s[b] = (b / `GROUP_BANKS == k / `PRE_LINES);
		return s;
	endfunction

	// window rows take two reads each
	function automatic int row_of(input int idx);
		if (idx < `STALL_FIRST)
			return idx;
		if (idx < `STALL_FIRST + 2 * win_rows)
			return `STALL_FIRST + (idx - `STALL_FIRST) / 2;
		return idx - win_rows;
	endfunction

	function automatic logic is_repeat(input int k);
		int idx;
		idx = k % half_reads;
		return idx >= `STALL_FIRST && idx < `STALL_FIRST + 2 * win_rows &&
			(idx - `STALL_FIRST) % 2 == 1;
	endfunction

	function automatic shift_t split_of(input int k);
		return shift_t'(`SPLIT_STEP * ((k / (2 * half_reads)) % 4));
	endfunction

	function automatic bank_addr_vec_t read_vec(input int k);
		int col_off, base, row;
		bank_addr_vec_t v;
		col_off = k / (2 * half_reads);
		base = `ROWS_PER_HALF * ((k / half_reads) % 2 + col_off / 4);
		row = row_of(k % half_reads);
		for (int b = 0; b < `NUM_BANKS; b++)
			v[b] = bank_addr_t'(base + row + ((b < split_of(k)) ? `ROWS_PER_HALF : 0));
		return v;
	endfunction

	task automatic value_error(input string name, input logic [223:0] exp_v,
			input logic [223:0] act_v);
		error_cnt++;
		$display("[ERROR] %0t %s expected %0h got %0h", $time, name, exp_v, act_v);
	endtask

	task automatic order_error(input string msg);
		error_cnt++;
		$display("[ERROR] %0t %s", $time, msg);
	endtask

	task automatic step(input int n);
		repeat (n) @(posedge clk);
		#10;
	endtask

	task automatic pulse_start();
		start = 1'b1;
		step(1);
		start = 1'b0;
	endtask

	assign in_pre = (bank_sel != '0);
	assign exp_sel = in_pre ? write_sel(pre_cnt) : '0;
	assign exp_wr = in_pre ? {`NUM_BANKS{bank_addr_t'(pre_cnt % `PRE_LINES)}} : '0;
	assign exp_rd = rd_en ? read_vec(rd_cnt) : '0;
	assign exp_split = rd_en ? split_of(rd_cnt) : '0;

	// model position, counted from what the DUT has issued so far
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pre_cnt <= 0;
			rd_cnt <= 0;
			runs_done <= 0;
			prev_in_pre <= 1'b0;
			prev_rd_en <= 1'b0;
			prev_done <= 1'b0;
			prev_rd_addr <= '0;
		end else begin
			prev_in_pre <= in_pre;
			prev_rd_en <= rd_en;
			prev_done <= done;
			prev_rd_addr <= rd_addr;
			if (done) begin
				pre_cnt <= 0;
				rd_cnt <= 0;
				runs_done <= runs_done + 1;
			end else begin
				pre_cnt <= pre_cnt + (in_pre ? 1 : 0);
				rd_cnt <= rd_cnt + (rd_en ? 1 : 0);
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) bank_sel == exp_sel)
		else value_error("bank_sel", $sampled(exp_sel), $sampled(bank_sel));
	assert property (@(posedge clk) disable iff (!rst_n) wr_addr == exp_wr)
		else value_error("wr_addr", $sampled(exp_wr), $sampled(wr_addr));
	assert property (@(posedge clk) disable iff (!rst_n) rd_addr == exp_rd)
		else value_error("rd_addr", $sampled(exp_rd), $sampled(rd_addr));
	assert property (@(posedge clk) disable iff (!rst_n) shift_value == exp_split)
		else value_error("shift_value", $sampled(exp_split), $sampled(shift_value));
	assert property (@(posedge clk) disable iff (!rst_n)
		in_pre |-> (!rd_en && rd_cnt == 0 && pre_cnt < total_pre &&
		(pre_cnt == 0 || prev_in_pre)))
		else order_error("preload write out of order or beyond 768 cycles");
	assert property (@(posedge clk) disable iff (!rst_n)
		(prev_in_pre && !in_pre) |-> (rd_en && pre_cnt == total_pre))
		else order_error("preload did not end after 768 writes straight into reads");
	assert property (@(posedge clk) disable iff (!rst_n)
		rd_en |-> (rd_cnt < total_reads && pre_cnt == total_pre && (rd_cnt == 0 || prev_rd_en)))
		else order_error("read out of order or beyond 518 cycles");
	assert property (@(posedge clk) disable iff (!rst_n)
		(prev_rd_en && !rd_en) == done)
		else order_error("done is not the single cycle after the last read");
	assert property (@(posedge clk) disable iff (!rst_n)
		done |-> rd_cnt == total_reads)
		else order_error("done came before all 518 reads");
	assert property (@(posedge clk) disable iff (!rst_n)
		prev_done |-> (!done && !in_pre && !rd_en))
		else order_error("outputs not idle after done");
	// repeat read of a window row
	assert property (@(posedge clk) disable iff (!rst_n)
		(rd_en && is_repeat(rd_cnt)) |-> rd_addr == prev_rd_addr)
		else value_error("rd_addr repeat", $sampled(prev_rd_addr), $sampled(rd_addr));
	assert property (@(posedge clk) disable iff (!rst_n)
		(rd_en && !is_repeat(rd_cnt) && rd_cnt % half_reads != 0) |->
		rd_addr[`NUM_BANKS-1] == prev_rd_addr[`NUM_BANKS-1] + 1)
		else value_error("rd_addr row step",
			$sampled(prev_rd_addr[`NUM_BANKS-1]) + 1,
			$sampled(rd_addr[`NUM_BANKS-1]));

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout: the runs did not finish within %0d cycles", cycle_limit);
			$display("TESTS FAILED");
			$finish;
		end
	end

	initial begin
		int gap;
		seed = 21;
		start = 1'b0;
		@(posedge rst_n);
		step(3);
		pulse_start();
		while (bank_sel == '0)
			step(1);
		// a start in the middle of preload must be ignored
		step(100);
		pulse_start();
		while (!done)
			step(1);
		gap = 1 + $unsigned($random(seed)) % 20;
		step(gap);
		pulse_start();
		while (!done)
			step(1);
		step(5);
		if (runs_done != 2)
			order_error("expected two completed runs");
		$display("checks failed: %0d, runs completed: %0d", error_cnt, runs_done);
		if (error_cnt == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+.
ref_mem_pkg.sv
ref_phase_decode.sv
preload_counter.sv
search_scan.sv
bank_addr_result.sv
ref_mem_ctrl.sv
tb_clock_gen.sv
ref_mem_ctrl_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module ref_mem_ctrl_tb -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1
	cat sim.log
	! grep -q "TESTS FAILED" sim.log

clean:
	rm -rf obj_dir sim.log
